// File: build.f
+incdir+include
design/ifetch_pkg.sv
design/walk_if.sv
design/pte_check.sv
design/xlat_cache.sv
design/ar_hold.sv
design/ifetch_ctrl.sv
design/ifetch_top.sv
tests/rd_mem_model.sv
tests/ifetch_tb.sv

// File: design/ar_hold.sv
`timescale 1ns/1ps

module ar_hold (
    input  logic                clk,
    input  logic                rstn,
    input  logic                issue,
    input  ifetch_pkg::paddr_t  issue_addr,
    output logic                ar_valid,
    output ifetch_pkg::paddr_t  ar_addr,
    input  logic                ar_ready
);

    import ifetch_pkg::*;

    logic   held_q;         // Address waiting for ar_ready
    paddr_t held_addr_q;

    // New issue goes straight out, held one takes over later
    assign ar_valid = held_q | issue;
    assign ar_addr  = held_q ? held_addr_q : issue_addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            held_q <= 1'b0;
        else if (ar_ready)
            held_q <= 1'b0;
        else if (issue)
            held_q <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (issue)
            held_addr_q <= issue_addr;
    end

    a_no_issue_held: assert property (@(posedge clk) disable iff (!rstn)
        issue |-> !held_q)
        else $error("issue while an address is still held");

    // Read channel rule seen from the memory side
    a_addr_stable: assert property (@(posedge clk) disable iff (!rstn)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)))
        else $error("ar_addr changed before ar_ready");

endmodule

// File: design/ifetch_ctrl.sv
`timescale 1ns/1ps
`include "ifetch_params.svh"

module ifetch_ctrl (
    input  logic                     clk,
    input  logic                     rstn,

    input  logic                     req_valid,
    input  ifetch_pkg::vaddr_t       req_pc,
    input  logic [`IFETCH_XLEN-1:0]  req_satp,
    input  logic                     req_prv,
    input  logic                     req_sum,
    input  logic                     req_flush,

    output logic                     resp_valid,
    output ifetch_pkg::vaddr_t       resp_pc,
    output logic [31:0]              resp_instr,
    output logic                     resp_exception,

    input  logic                     r_valid,
    input  logic [`IFETCH_XLEN-1:0]  r_data,

    walk_if.ctrl                     walk,

    output ifetch_pkg::vpn_t         lookup_vpn,
    input  logic                     hit,
    input  ifetch_pkg::ppn_t         hit_ppn,
    output logic                     fill,
    output ifetch_pkg::vpn_t         fill_vpn,
    output ifetch_pkg::ppn_t         fill_ppn,
    output logic                     flush,

    output logic                     issue,
    output ifetch_pkg::paddr_t       issue_addr
);

    import ifetch_pkg::*;

    localparam int XL = `IFETCH_XLEN;
    localparam int VA = `IFETCH_VA_LEN;
    localparam int PA = `IFETCH_PA_LEN;
    localparam int PO = `IFETCH_PG_OFFS;

    fetch_state_t state_q, state_d;
    walk_level_t  level_q, level_d;
    vaddr_t       pc_q;
    logic         prv_q;
    logic         sum_q;
    logic         outstanding_q;    // A read is in flight
    logic         canonical;
    logic         xlat_on;

    // Upper bits must all copy bit 38
    assign canonical = ~|req_pc[XL-1:VA-1] | &req_pc[XL-1:VA-1];
    assign xlat_on   = req_satp[XL-1];      // Sv39 mode selected

    assign lookup_vpn = req_pc[VA-1:PO];
    assign flush      = req_valid & req_flush;
    assign fill_vpn   = pc_q[VA-1:PO];
    assign fill_ppn   = walk.leaf_ppn;

    assign walk.pte    = r_data;
    assign walk.level  = level_q;
    assign walk.vpn_pc = pc_q;
    assign walk.prv    = prv_q;
    assign walk.sum    = sum_q;

    assign resp_pc    = pc_q;
    assign resp_instr = pc_q[2] ? r_data[63:32] : r_data[31:0];

    always_comb begin
        state_d        = state_q;
        level_d        = level_q;
        resp_valid     = 1'b0;
        resp_exception = 1'b0;
        fill           = 1'b0;
        issue          = 1'b0;
        issue_addr     = '0;

        case (state_q)
            ST_IDLE_FETCH: begin
                if (r_valid && outstanding_q)
                    resp_valid = 1'b1;
            end
            ST_FAULT: begin
                resp_valid     = 1'b1;
                resp_exception = 1'b1;
                state_d        = ST_IDLE_FETCH;
            end
            ST_WALK: begin
                if (r_valid) begin
                    if (walk.fault) begin
                        state_d = ST_FAULT;
                    end else if (walk.non_leaf) begin
                        // Descend one level
                        issue      = 1'b1;
                        issue_addr = walk.next_addr;
                        level_d    = (level_q == LVL_2) ? LVL_1 : LVL_0;
                    end else begin
                        fill       = 1'b1;
                        issue      = 1'b1;
                        issue_addr = {walk.leaf_ppn, pc_q[PO-1:2], 2'b00};
                        state_d    = ST_IDLE_FETCH;
                    end
                end
            end
            default: state_d = ST_IDLE_FETCH;
        endcase

        if (req_valid) begin
            if (!xlat_on) begin
                issue      = 1'b1;      // Bare physical fetch
                issue_addr = {req_pc[PA-1:2], 2'b00};
            end else if (!canonical) begin
                state_d = ST_FAULT;
            end else if (hit) begin
                issue      = 1'b1;
                issue_addr = {hit_ppn, req_pc[PO-1:2], 2'b00};
            end else begin
                // Root PTE read
                issue      = 1'b1;
                issue_addr = {req_satp[PA-PO-1:0], req_pc[VA-1:VA-9], 3'b000};
                state_d    = ST_WALK;
                level_d    = LVL_2;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q       <= ST_IDLE_FETCH;
            level_q       <= LVL_2;
            outstanding_q <= 1'b0;
        end else begin
            state_q <= state_d;
            level_q <= level_d;
            if (issue)
                outstanding_q <= 1'b1;
            else if (r_valid)
                outstanding_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            pc_q  <= {req_pc[XL-1:1], 1'b0};
            prv_q <= req_prv;
            sum_q <= req_sum;
        end
    end

    // CPU waits for resp_valid before the next request
    a_no_req_busy: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> (!outstanding_q && state_q == ST_IDLE_FETCH))
        else $error("request while a fetch or walk is outstanding");

endmodule

// File: design/ifetch_pkg.sv
`include "ifetch_params.svh"

package ifetch_pkg;

    typedef logic [`IFETCH_XLEN-1:0] vaddr_t;     // Full 64-bit PC
    typedef logic [`IFETCH_PA_LEN-1:0] paddr_t;
    typedef logic [`IFETCH_PA_LEN-`IFETCH_PG_OFFS-1:0] ppn_t;
    typedef logic [`IFETCH_VA_LEN-`IFETCH_PG_OFFS-1:0] vpn_t;

    // Table level being read, root first
    typedef enum logic [1:0] {
        LVL_2,
        LVL_1,
        LVL_0
    } walk_level_t;

    typedef enum logic [2:0] {
        ST_IDLE_FETCH,
        ST_FAULT,
        ST_WALK
    } fetch_state_t;

    // Sv39 page table entry layout
    typedef struct packed {
        logic [9:0] rsvd;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

endpackage

// File: design/ifetch_top.sv
`timescale 1ns/1ps
`include "ifetch_params.svh"

module ifetch_top (
    input  logic                     clk,
    input  logic                     rstn,

    // CPU side
    input  logic                     req_valid,
    input  ifetch_pkg::vaddr_t       req_pc,
    input  logic [`IFETCH_XLEN-1:0]  req_satp,
    input  logic                     req_prv,
    input  logic                     req_sum,
    input  logic                     req_flush,
    output logic                     resp_valid,
    output ifetch_pkg::vaddr_t       resp_pc,
    output logic [31:0]              resp_instr,
    output logic                     resp_exception,

    // Memory read channel
    output logic                     ar_valid,
    output ifetch_pkg::paddr_t       ar_addr,
    input  logic                     ar_ready,
    input  logic                     r_valid,
    input  logic [`IFETCH_XLEN-1:0]  r_data
);

    import ifetch_pkg::*;

    vpn_t   lookup_vpn;
    logic   hit;
    ppn_t   hit_ppn;
    logic   fill;
    vpn_t   fill_vpn;
    ppn_t   fill_ppn;
    logic   flush;
    logic   issue;
    paddr_t issue_addr;

    walk_if walk_i ();

    ifetch_ctrl ctrl_i (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_pc         (req_pc),
        .req_satp       (req_satp),
        .req_prv        (req_prv),
        .req_sum        (req_sum),
        .req_flush      (req_flush),
        .resp_valid     (resp_valid),
        .resp_pc        (resp_pc),
        .resp_instr     (resp_instr),
        .resp_exception (resp_exception),
        .r_valid        (r_valid),
        .r_data         (r_data),
        .walk           (walk_i.ctrl),
        .lookup_vpn     (lookup_vpn),
        .hit            (hit),
        .hit_ppn        (hit_ppn),
        .fill           (fill),
        .fill_vpn       (fill_vpn),
        .fill_ppn       (fill_ppn),
        .flush          (flush),
        .issue          (issue),
        .issue_addr     (issue_addr)
    );

    pte_check pte_check_i (
        .walk (walk_i.chk)
    );

    xlat_cache xlat_cache_i (
        .clk        (clk),
        .rstn       (rstn),
        .lookup_vpn (lookup_vpn),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .fill       (fill),
        .fill_vpn   (fill_vpn),
        .fill_ppn   (fill_ppn),
        .flush      (flush)
    );

    ar_hold ar_hold_i (
        .clk        (clk),
        .rstn       (rstn),
        .issue      (issue),
        .issue_addr (issue_addr),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .ar_ready   (ar_ready)
    );

endmodule

// File: design/pte_check.sv
`timescale 1ns/1ps
`include "ifetch_params.svh"

module pte_check (
    walk_if.chk walk
);

    import ifetch_pkg::*;

    localparam int PO  = `IFETCH_PG_OFFS;
    localparam int SEG = `IFETCH_VPN_SEG;

    pte_t pte_f;
    logic is_ptr;
    logic bad_perm;
    logic priv_bad;
    logic misaligned;

    assign pte_f = pte_t'(walk.pte);

    // V set with R, W and X clear points to the next table
    assign is_ptr   = pte_f.v & ~pte_f.r & ~pte_f.w & ~pte_f.x;
    assign bad_perm = pte_f.w & ~pte_f.r;       // Reserved W without R

    // User page from S-mode needs SUM, S page never from U-mode
    assign priv_bad = pte_f.u ? (walk.prv & ~walk.sum) : ~walk.prv;

    always_comb begin
        case (walk.level)
            LVL_2:   misaligned = |pte_f.ppn[2*SEG-1:0];
            LVL_1:   misaligned = |pte_f.ppn[SEG-1:0];
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (!pte_f.v || bad_perm)
            walk.fault = 1'b1;
        else if (is_ptr)
            walk.fault = (walk.level == LVL_0);     // No table below level 0
        else
            walk.fault = ~pte_f.a | priv_bad | misaligned;
    end

    assign walk.non_leaf = is_ptr;

    always_comb begin
        case (walk.level)
            LVL_2:   walk.next_addr = {pte_f.ppn, walk.vpn_pc[PO+2*SEG-1:PO+SEG], 3'b000};
            default: walk.next_addr = {pte_f.ppn, walk.vpn_pc[PO+SEG-1:PO], 3'b000};
        endcase
    end

    // Superpages take the low PPN bits from the PC
    always_comb begin
        case (walk.level)
            LVL_2: walk.leaf_ppn = {pte_f.ppn[$bits(ppn_t)-1:2*SEG],
                                    walk.vpn_pc[PO+2*SEG-1:PO]};
            LVL_1: walk.leaf_ppn = {pte_f.ppn[$bits(ppn_t)-1:SEG],
                                    walk.vpn_pc[PO+SEG-1:PO]};
            default: walk.leaf_ppn = pte_f.ppn;
        endcase
    end

endmodule

// File: design/walk_if.sv
`timescale 1ns/1ps

interface walk_if;

    import ifetch_pkg::*;

    // Walk context from the controller
    logic [63:0] pte;
    walk_level_t level;
    vaddr_t      vpn_pc;
    logic        prv;       // 1 for supervisor
    logic        sum;

    // Decoded result of the current PTE
    logic        fault;
    logic        non_leaf;
    paddr_t      next_addr;
    ppn_t        leaf_ppn;

    modport ctrl (
        output pte, level, vpn_pc, prv, sum,
        input  fault, non_leaf, next_addr, leaf_ppn
    );

    // Seen from the PTE checker
    modport chk (
        input  pte, level, vpn_pc, prv, sum,
        output fault, non_leaf, next_addr, leaf_ppn
    );

endinterface

// File: design/xlat_cache.sv
`timescale 1ns/1ps

module xlat_cache (
    input  logic              clk,
    input  logic              rstn,
    input  ifetch_pkg::vpn_t  lookup_vpn,
    output logic              hit,
    output ifetch_pkg::ppn_t  hit_ppn,
    input  logic              fill,
    input  ifetch_pkg::vpn_t  fill_vpn,
    input  ifetch_pkg::ppn_t  fill_ppn,
    input  logic              flush
);

    import ifetch_pkg::*;

    logic valid_q;
    vpn_t vpn_q;
    ppn_t ppn_q;

    // A flush in the lookup cycle already misses
    assign hit     = valid_q & ~flush & (lookup_vpn == vpn_q);
    assign hit_ppn = ppn_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            valid_q <= 1'b0;
        else if (flush)
            valid_q <= 1'b0;    // Flush wins over fill
        else if (fill)
            valid_q <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fill && !flush) begin
            vpn_q <= fill_vpn;
            ppn_q <= fill_ppn;
        end
    end

    // Fills end a walk, flushes come with a new request
    a_fill_flush: assert property (@(posedge clk) disable iff (!rstn)
        !(fill && flush))
        else $error("fill and flush in the same cycle");

endmodule

// File: include/ifetch_params.svh
`ifndef IFETCH_PARAMS_SVH
`define IFETCH_PARAMS_SVH

// Core and Sv39 address widths
`define IFETCH_XLEN     64
`define IFETCH_VA_LEN   39
`define IFETCH_PA_LEN   56
`define IFETCH_PG_OFFS  12
`define IFETCH_VPN_SEG  9     // Bits of VPN per table level

// Testbench sizing
`define IFETCH_TB_NUM_REQ       48
`define IFETCH_TB_CYC_PER_REQ   200

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ifetch_tb -f build.f -o ifetch_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build stopped with status $build_status"
    exit $build_status
fi

./obj_dir/ifetch_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit $sim_status
fi

exit 0

// File: tests/ifetch_tb.sv
`timescale 1ns/1ps
`include "ifetch_params.svh"

module ifetch_tb;

    import ifetch_pkg::*;

    localparam int NUM_REQ     = `IFETCH_TB_NUM_REQ;
    localparam int CYC_PER_REQ = `IFETCH_TB_CYC_PER_REQ;

    localparam ppn_t        ROOT   = 44'h100;
    localparam logic [63:0] SATP   = {4'h8, 16'h0, ROOT};   // Sv39 mode
    localparam logic [7:0]  PTR    = 8'h01;
    localparam logic [7:0]  LEAF_S = 8'h4b;    // V R X A
    localparam logic [7:0]  LEAF_U = 8'h5b;    // Same plus U

    logic        clk;
    logic        rstn;
    logic        req_valid;
    vaddr_t      req_pc;
    logic [63:0] req_satp;
    logic        req_prv;
    logic        req_sum;
    logic        req_flush;
    logic        resp_valid;
    vaddr_t      resp_pc;
    logic [31:0] resp_instr;
    logic        resp_exception;
    logic        ar_valid;
    paddr_t      ar_addr;
    logic        ar_ready;
    logic        r_valid;
    logic [63:0] r_data;

    int seed = 32'hf762_62e0;
    int issued;
    int resp_count;

    string       exp_name_q[$];
    vaddr_t      exp_pc_q[$];
    logic        exp_exc_q[$];
    logic [31:0] exp_instr_q[$];

    // Expected state of the single-entry translation cache
    logic ref_valid;
    vpn_t ref_vpn;
    ppn_t ref_ppn;

    ifetch_top dut_i (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_pc         (req_pc),
        .req_satp       (req_satp),
        .req_prv        (req_prv),
        .req_sum        (req_sum),
        .req_flush      (req_flush),
        .resp_valid     (resp_valid),
        .resp_pc        (resp_pc),
        .resp_instr     (resp_instr),
        .resp_exception (resp_exception),
        .ar_valid       (ar_valid),
        .ar_addr        (ar_addr),
        .ar_ready       (ar_ready),
        .r_valid        (r_valid),
        .r_data         (r_data)
    );

    rd_mem_model mem_i (
        .clk      (clk),
        .rstn     (rstn),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data)
    );

    always #50 clk = ~clk;

    function automatic logic [63:0] default_word(input logic [52:0] w);
        return {w[52:21] ^ 32'ha5c3_0f1e, ~w[31:0]};
    endfunction

    function automatic logic [63:0] peek(input logic [52:0] w);
        if (mem_i.mem.exists(w))
            return mem_i.mem[w];
        return default_word(w);
    endfunction

    function automatic logic [63:0] make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {10'h0, ppn, 2'b00, flags};
    endfunction

    // Canonical VA with the given root index and random lower bits
    function automatic vaddr_t make_va(input logic [8:0] vpn2);
        return {25'h0, vpn2, 18'($random(seed)), 10'($random(seed)), 2'b00};
    endfunction

    function automatic vaddr_t same_page(input vaddr_t va);
        return {va[63:12], 10'($random(seed)), 2'b00};
    endfunction

    // Sv39 fetch as the CPU should see it with cache and flush
    function automatic void ref_fetch(input vaddr_t pc, input logic [63:0] satp,
            input logic prv, input logic sum, input logic flush,
            output logic exc, output logic [31:0] instr);
        vaddr_t      pc_a;
        vpn_t        vpn;
        ppn_t        tbl;
        ppn_t        ppn;
        ppn_t        mask;
        logic [63:0] pte;
        logic [63:0] word;
        logic [55:0] pa;
        logic [8:0]  idx;
        int          lvl;
        logic        done;

        pc_a  = {pc[63:1], 1'b0};
        exc   = 1'b0;
        instr = '0;
        ppn   = '0;
        if (flush)
            ref_valid = 1'b0;
        if (satp[63:60] == 4'h0) begin
            pa = pc_a[55:0];
        end else if (pc_a[63:38] != '0 && pc_a[63:38] != '1) begin
            exc = 1'b1;
            return;
        end else begin
            vpn = pc_a[38:12];
            if (ref_valid && ref_vpn == vpn) begin
                ppn = ref_ppn;
            end else begin
                tbl  = satp[43:0];
                lvl  = 2;
                done = 1'b0;
                while (!done) begin
                    idx  = 9'(vpn >> (9 * lvl));
                    pte  = peek({tbl, idx});
                    mask = (44'h1 << (9 * lvl)) - 44'h1;
                    if (!pte[0] || (pte[2] && !pte[1])) begin
                        exc = 1'b1;
                    end else if (!pte[1] && !pte[3]) begin
                        if (lvl == 0)
                            exc = 1'b1;     // Pointer below the last level
                        else begin
                            tbl = pte[53:10];
                            lvl--;
                        end
                    end else if (!pte[6]) begin
                        exc = 1'b1;
                    end else if (pte[4] ? (prv && !sum) : !prv) begin
                        exc = 1'b1;
                    end else if ((pte[53:10] & mask) != '0) begin
                        exc = 1'b1;
                    end else begin
                        ppn       = (pte[53:10] & ~mask) | (44'(vpn) & mask);
                        ref_valid = 1'b1;
                        ref_vpn   = vpn;
                        ref_ppn   = ppn;
                        done      = 1'b1;
                    end
                    if (exc)
                        return;
                end
            end
            pa = {ppn, pc_a[11:0]};
        end
        word  = peek(pa[55:3]);
        instr = pa[2] ? word[63:32] : word[31:0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic put_pte(input ppn_t table_ppn, input logic [8:0] idx,
            input logic [63:0] pte);
        mem_i.mem[{table_ppn, idx}] = pte;
    endtask

    task automatic map_4k(input vaddr_t va, input ppn_t l1, input ppn_t l0,
            input ppn_t leaf, input logic [7:0] flags);
        put_pte(ROOT, va[38:30], make_pte(l1, PTR));
        put_pte(l1, va[29:21], make_pte(l0, PTR));
        put_pte(l0, va[20:12], make_pte(leaf, flags));
    endtask

    task automatic fetch(input string name, input vaddr_t pc, input logic [63:0] satp,
            input logic prv, input logic sum, input logic flush);
        logic        exc;
        logic [31:0] instr;

        ref_fetch(pc, satp, prv, sum, flush, exc, instr);
        exp_name_q.push_back(name);
        exp_pc_q.push_back({pc[63:1], 1'b0});
        exp_exc_q.push_back(exc);
        exp_instr_q.push_back(instr);
        issued++;
        @(posedge clk);
        req_valid <= 1'b1;
        req_pc    <= pc;
        req_satp  <= satp;
        req_prv   <= prv;
        req_sum   <= sum;
        req_flush <= flush;
        @(posedge clk);
        req_valid <= 1'b0;
        req_flush <= 1'b0;
        while (resp_count < issued)
            @(posedge clk);
    endtask

    task automatic bare_fetches();
        vaddr_t pc;

        for (int i = 0; i < 12; i++) begin
            pc = {34'h0, 2'b01, 26'($random(seed)), 2'b00};
            mem_i.mem[pc[55:3]] = {$random(seed), $random(seed)};
            fetch($sformatf("bare_%0d", i), pc, 64'h0, 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic walks_4k();
        vaddr_t va;

        for (int i = 0; i < 8; i++) begin
            va = make_va(9'(i + 1));
            map_4k(va, 44'(512 + i), 44'(768 + i), {24'h0, 4'h8, 16'($random(seed))}, LEAF_S);
            fetch($sformatf("walk4k_%0d", i), va, SATP, 1'b1, 1'b0, 1'b0);
            fetch($sformatf("hit4k_%0d", i), same_page(va), SATP, 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic superpage_walks();
        vaddr_t va;

        va = make_va(9'd20);
        put_pte(ROOT, va[38:30], make_pte({26'h5, 18'h0}, LEAF_S));
        fetch("giga", va, SATP, 1'b1, 1'b0, 1'b0);
        va = make_va(9'd21);
        put_pte(ROOT, va[38:30], make_pte(44'h221, PTR));
        put_pte(44'h221, va[29:21], make_pte({35'h123, 9'h0}, LEAF_S));
        fetch("mega", va, SATP, 1'b1, 1'b0, 1'b0);
        va = make_va(9'd22);
        put_pte(ROOT, va[38:30], make_pte({26'h6, 18'h40}, LEAF_S));
        fetch("giga_misaligned", va, SATP, 1'b1, 1'b0, 1'b0);
        va = make_va(9'd23);
        put_pte(ROOT, va[38:30], make_pte(44'h223, PTR));
        put_pte(44'h223, va[29:21], make_pte({35'h124, 9'h1}, LEAF_S));
        fetch("mega_misaligned", va, SATP, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic fault_cases();
        vaddr_t va;
        vaddr_t va2;

        va = make_va(9'd24);
        put_pte(ROOT, va[38:30], make_pte(44'h240, 8'h4e));    // All but V
        fetch("invalid_root", va, SATP, 1'b1, 1'b0, 1'b0);
        va = make_va(9'd25);
        put_pte(ROOT, va[38:30], make_pte(44'h225, PTR));
        put_pte(44'h225, va[29:21], 64'h0);
        fetch("invalid_l1", va, SATP, 1'b1, 1'b0, 1'b0);
        va = make_va(9'd26);
        map_4k(va, 44'h226, 44'h326, 44'h9026, 8'h0b);
        fetch("a_clear", va, SATP, 1'b1, 1'b0, 1'b0);
        va = make_va(9'd27);
        put_pte(ROOT, va[38:30], make_pte(44'h9027, 8'h45));   // W without R
        fetch("w_no_r", va, SATP, 1'b1, 1'b0, 1'b0);

        va = make_va(9'd28);
        map_4k(va, 44'h228, 44'h328, 44'h9028, LEAF_U);
        fetch("u_page_s_nosum", va, SATP, 1'b1, 1'b0, 1'b0);
        fetch("u_page_s_sum", va, SATP, 1'b1, 1'b1, 1'b0);
        va2 = {va[63:21], va[20:12] ^ 9'h1, va[11:0]};
        put_pte(44'h328, va2[20:12], make_pte(44'h9128, LEAF_U));
        fetch("u_page_u", va2, SATP, 1'b0, 1'b0, 1'b0);
        va = make_va(9'd29);
        map_4k(va, 44'h229, 44'h329, 44'h9029, LEAF_S);
        fetch("s_page_u_nosum", va, SATP, 1'b0, 1'b0, 1'b0);
        fetch("s_page_u_sum", va, SATP, 1'b0, 1'b1, 1'b0);

        va = make_va(9'd30);
        map_4k(va, 44'h22a, 44'h32a, 44'h42a, PTR);
        fetch("ptr_at_l0", va, SATP, 1'b1, 1'b0, 1'b0);
        fetch("noncanon_high", 64'h0000_0040_0000_1000, SATP, 1'b1, 1'b0, 1'b0);
        fetch("noncanon_low", 64'hffff_ff80_0000_2005, SATP, 1'b1, 1'b0, 1'b0);
    endtask

    // Page table rewrite is only seen after a flush
    task automatic remap_and_flush();
        vaddr_t va;
        vaddr_t va_b;

        va = make_va(9'd31);
        map_4k(va, 44'h22b, 44'h32b, 44'h9100, LEAF_S);
        fetch("remap_first", va, SATP, 1'b1, 1'b0, 1'b0);
        put_pte(44'h32b, va[20:12], make_pte(44'h9200, LEAF_S));
        va_b = same_page(va);
        fetch("remap_stale", va_b, SATP, 1'b1, 1'b0, 1'b0);
        fetch("remap_flush", va_b, SATP, 1'b1, 1'b0, 1'b1);
        fetch("remap_new", va, SATP, 1'b1, 1'b0, 1'b0);
    endtask

    always @(posedge clk) begin
        if (rstn && resp_valid) begin
            if (exp_name_q.size() == 0) begin
                $display("Test failures found");
                $fatal(1, "response arrived with no request outstanding");
            end else begin
                check_value({exp_name_q[0], "_pc"}, exp_pc_q[0], resp_pc);
                check_value({exp_name_q[0], "_exc"}, 64'(exp_exc_q[0]), 64'(resp_exception));
                if (!exp_exc_q[0])
                    check_value({exp_name_q[0], "_instr"}, 64'(exp_instr_q[0]),
                                64'(resp_instr));
                void'(exp_name_q.pop_front());
                void'(exp_pc_q.pop_front());
                void'(exp_exc_q.pop_front());
                void'(exp_instr_q.pop_front());
                resp_count <= resp_count + 1;
            end
        end
    end

    initial begin
        repeat (NUM_REQ * CYC_PER_REQ) @(posedge clk);
        $display("Test failures found");
        $fatal(1, "timeout after %0d cycles, a response never arrived", NUM_REQ * CYC_PER_REQ);
    end

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_pc     = '0;
        req_satp   = '0;
        req_prv    = 1'b0;
        req_sum    = 1'b0;
        req_flush  = 1'b0;
        issued     = 0;
        resp_count = 0;
        ref_valid  = 1'b0;
        ref_vpn    = '0;
        ref_ppn    = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        bare_fetches();
        walks_4k();
        superpage_walks();
        fault_cases();
        remap_and_flush();
        repeat (10) @(posedge clk);     // Catch stray responses

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: tests/rd_mem_model.sv
`timescale 1ns/1ps

module rd_mem_model #(
    parameter int unsigned SEED = 32'hf762_62e0
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                ar_valid,
    input  ifetch_pkg::paddr_t  ar_addr,
    output logic                ar_ready,
    output logic                r_valid,
    output logic [63:0]         r_data
);

    import ifetch_pkg::*;

    logic [63:0] mem [logic [52:0]];    // Keyed by 8-byte word address
    int          seed = SEED;
    logic        busy;
    logic [1:0]  delay;
    logic [52:0] word_q;

    // Unwritten words read back a pattern of their own address
    function automatic logic [63:0] default_word(input logic [52:0] w);
        return {w[52:21] ^ 32'ha5c3_0f1e, ~w[31:0]};
    endfunction

    function automatic logic [63:0] read_word(input logic [52:0] w);
        if (mem.exists(w))
            return mem[w];
        return default_word(w);
    endfunction

    always @(posedge clk or negedge rstn) begin
        logic [31:0] rnd;

        if (!rstn) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            busy     <= 1'b0;
            delay    <= '0;
            word_q   <= '0;
        end else begin
            rnd = $random(seed);
            ar_ready <= (rnd[1:0] != 2'b00);    // Stall about one cycle in four
            r_valid  <= 1'b0;
            if (busy) begin
                if (delay == 2'd0) begin
                    r_valid <= 1'b1;
                    r_data  <= read_word(word_q);
                    busy    <= 1'b0;
                end else begin
                    delay <= delay - 2'd1;
                end
            end else if (ar_valid && ar_ready) begin
                busy   <= 1'b1;
                word_q <= ar_addr[55:3];
                delay  <= rnd[3:2];     // Extra wait cycles
            end
        end
    end

endmodule
